/* src/vfa_pkg.sv */
package vfa_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Widths and timing
  ///////////////////////////////////////////////////////////////////////

  // One IEEE-754 single precision word
  localparam int FLOAT_W = 32;

  // Run length and element index
  localparam int LEN_W = 16;

  // Core latency from start pulse to ready pulse
  localparam int CORE_LAT = 3;

  // All-ones exponent, infinity encoding
  localparam logic [7:0] EXP_MAX = 8'd255;

  ///////////////////////////////////////////////////////////////////////
  // Types
  ///////////////////////////////////////////////////////////////////////

  // Field split of a float
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
  } float_fields_t;

  // Same word, raw bits at the ports, fields in the core
  typedef union packed {
    logic [FLOAT_W-1:0] raw;
    float_fields_t      f;
  } float_word_u;

  // Operand pair handed from capture to core
  typedef struct packed {
    float_word_u a;
    float_word_u b;
    logic        sub;  // 1 = a - b
  } elem_req_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    CAPTURE,
    COMPUTE
  } vfa_state_e;

endpackage

/* src/vfa_ctrl_fsm.sv */
module vfa_ctrl_fsm (
  input  logic CLK,
  input  logic RST,
  input  logic start,
  input  logic both_full,
  input  logic core_ready,
  input  logic last,
  output logic cap_en,
  output logic core_start,
  output logic cnt_load,
  output logic cnt_step,
  output logic out_en,
  output logic done
);
  import vfa_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // State register
  ///////////////////////////////////////////////////////////////////////

  vfa_state_e state;
  vfa_state_e state_nxt;

  // Both operands held, launch on the next edge
  logic launch;

  assign launch = (state == CAPTURE) && both_full;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // Wait for a run
        if (start) begin
          state_nxt = CAPTURE;
        end
      end
      CAPTURE: begin
        // Wait for the operand pair
        if (both_full) begin
          state_nxt = COMPUTE;
        end
      end
      COMPUTE: begin
        // Result back, either finish or take the next pair
        if (core_ready) begin
          state_nxt = last ? IDLE : CAPTURE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE;
      core_start <= 1'b0;
    end else begin
      state      <= state_nxt;
      // One cycle start pulse, a cycle after both flags rise
      core_start <= launch;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Strobe decode
  ///////////////////////////////////////////////////////////////////////

  // Operand strobes only count while waiting for a pair
  assign cap_en   = (state == CAPTURE);

  // Latch length and clear index on an accepted START
  assign cnt_load = (state == IDLE) && start;

  // Result emission
  assign out_en   = (state == COMPUTE) && core_ready;
  assign cnt_step = out_en && !last;
  assign done     = out_en && last;

  // Core result only expected while a launch is outstanding
  a_ready_in_compute: assert property (@(posedge CLK) disable iff (RST)
    core_ready |-> state == COMPUTE);

  // No operand pair waiting while a result leaves
  a_empty_on_out: assert property (@(posedge CLK) disable iff (RST)
    out_en |-> !both_full);

endmodule

/* src/vfa_elem_counter.sv */
module vfa_elem_counter (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      load,
  input  logic                      step,
  input  logic [vfa_pkg::LEN_W-1:0] size,
  output logic                      last
);
  import vfa_pkg::*;

  // Latched run length and running index
  logic [LEN_W-1:0] len_q;
  logic [LEN_W-1:0] idx_q;

  // Zero length runs as one element
  logic [LEN_W-1:0] len_eff;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      len_q <= '0;
      idx_q <= '0;
    end else if (load) begin
      len_q <= size;
      idx_q <= '0;
    end else if (step) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign len_eff = (len_q == '0) ? LEN_W'(1) : len_q;

  // Final element of the run
  assign last = (idx_q == len_eff - 1'b1);

  // Software should never start an empty run
  a_nonzero_len: assert property (@(posedge CLK) disable iff (RST)
    load |-> size != '0);

endmodule

/* src/vfa_operand_capture.sv */
module vfa_operand_capture (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        cap_en,
  input  logic                        clr,
  input  logic                        a_en,
  input  logic [vfa_pkg::FLOAT_W-1:0] a,
  input  logic                        b_en,
  input  logic [vfa_pkg::FLOAT_W-1:0] b,
  input  logic                        op,
  output logic                        both_full,
  output vfa_pkg::elem_req_t          req
);

  // Per operand full flags
  logic a_full;
  logic b_full;

  // Qualified strobes
  logic a_wr;
  logic b_wr;

  assign a_wr = cap_en && a_en;
  assign b_wr = cap_en && b_en;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else if (clr) begin
      // Pair handed to the core
      a_full <= 1'b0;
      b_full <= 1'b0;
    end else begin
      if (a_wr) a_full <= 1'b1;
      if (b_wr) b_full <= 1'b1;
    end
  end

  // Operand words, held until the next pair
  always_ff @(posedge CLK) begin
    if (a_wr) req.a.raw <= a;
    if (b_wr) req.b.raw <= b;
    // Last store wins, so op is taken with the second operand
    if (a_wr || b_wr) req.sub <= op;
  end

  assign both_full = a_full && b_full;

  // A second strobe for an already held operand is a protocol error
  a_no_rewrite: assert property (@(posedge CLK) disable iff (RST)
    (a_wr |-> !a_full) and (b_wr |-> !b_full));

endmodule

/* src/vfa_float_add_core.sv */
module vfa_float_add_core (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  vfa_pkg::elem_req_t   req,
  output logic                 ready,
  output vfa_pkg::float_word_u result
);
  import vfa_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Stage 1, align
  ///////////////////////////////////////////////////////////////////////

  // Mantissa working format: hidden one at bit 26, 3 guard bits below
  float_fields_t fa;
  float_fields_t fb;
  float_fields_t op_hi;
  float_fields_t op_lo;
  logic          a_big;
  logic [7:0]    e_diff;
  logic [26:0]   m_hi;
  logic [26:0]   m_lo;

  always_comb begin
    fa      = req.a.f;
    fb      = req.b.f;
    // Subtract as add of negated b
    fb.sign = req.b.f.sign ^ req.sub;
    // Magnitude compare on exp and mantissa together
    a_big   = {fa.exp, fa.man} >= {fb.exp, fb.man};
    op_hi   = a_big ? fa : fb;
    op_lo   = a_big ? fb : fa;
    e_diff  = op_hi.exp - op_lo.exp;
    // Zero exponent flushes to zero
    m_hi    = (op_hi.exp == '0) ? '0 : {1'b1, op_hi.man, 3'b000};
    m_lo    = (op_lo.exp == '0) ? '0 : ({1'b1, op_lo.man, 3'b000} >> e_diff);
  end

  logic        s1_valid;
  logic        s1_sign;
  logic        s1_eff_sub;
  logic [7:0]  s1_exp;
  logic [26:0] s1_m_hi;
  logic [26:0] s1_m_lo;

  always_ff @(posedge CLK) begin
    s1_sign    <= op_hi.sign;
    s1_eff_sub <= op_hi.sign ^ op_lo.sign;
    s1_exp     <= op_hi.exp;
    s1_m_hi    <= m_hi;
    s1_m_lo    <= m_lo;
  end

  ///////////////////////////////////////////////////////////////////////
  // Stage 2, mantissa add
  ///////////////////////////////////////////////////////////////////////

  logic        s2_valid;
  logic        s2_sign;
  logic [7:0]  s2_exp;
  logic [27:0] s2_sum;  // bit 27 catches the carry

  always_ff @(posedge CLK) begin
    s2_sign <= s1_sign;
    s2_exp  <= s1_exp;
    // Larger magnitude first, so the difference never goes negative
    if (s1_eff_sub) begin
      s2_sum <= {1'b0, s1_m_hi} - {1'b0, s1_m_lo};
    end else begin
      s2_sum <= {1'b0, s1_m_hi} + {1'b0, s1_m_lo};
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Stage 3, normalize and pack
  ///////////////////////////////////////////////////////////////////////

  logic [4:0]    lz;
  logic          found;
  logic [27:0]   norm;
  logic [9:0]    exp_inc;
  logic [9:0]    exp_n;
  float_fields_t res_f;

  // Leading one search from the carry bit down
  always_comb begin
    lz    = '0;
    found = 1'b0;
    for (int i = 27; i >= 0; i--) begin
      if (!found && s2_sum[i]) begin
        lz    = 5'(27 - i);
        found = 1'b1;
      end
    end
  end

  assign norm    = s2_sum << lz;
  // Leading one at bit 27 means exponent plus one
  assign exp_inc = {2'b00, s2_exp} + 10'd1;
  assign exp_n   = exp_inc - {5'd0, lz};

  always_comb begin
    res_f.sign = s2_sign;
    res_f.exp  = exp_n[7:0];
    // Guard bits dropped, truncation toward zero
    res_f.man  = norm[26:4];
    if (!found || (exp_inc <= {5'd0, lz})) begin
      // Exact zero or underflow, always +0
      res_f = '0;
    end else if (exp_n >= {2'b00, EXP_MAX}) begin
      // Signed infinity
      res_f.exp = EXP_MAX;
      res_f.man = '0;
    end
  end

  logic        s3_valid;
  float_word_u s3_res;

  always_ff @(posedge CLK) begin
    s3_res.f <= res_f;
  end

  // Valid bit per stage
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= start;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  assign ready  = s3_valid;
  assign result = s3_res;

  // Operand pair held steady into the launch edge
  a_req_stable: assert property (@(posedge CLK) disable iff (RST)
    start |-> $stable(req));

endmodule

/* src/vector_float_adder.sv */
module vector_float_adder (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        START,
  input  logic                        OPERATION,
  input  logic [vfa_pkg::LEN_W-1:0]   SIZE_IN,
  input  logic                        DATA_A_IN_ENABLE,
  input  logic [vfa_pkg::FLOAT_W-1:0] DATA_A_IN,
  input  logic                        DATA_B_IN_ENABLE,
  input  logic [vfa_pkg::FLOAT_W-1:0] DATA_B_IN,
  output logic                        READY,
  output logic                        DATA_OUT_ENABLE,
  output logic [vfa_pkg::FLOAT_W-1:0] DATA_OUT
);
  import vfa_pkg::*;

  ///////////////////////////////////////////////////////////////////////
  // Internal wiring
  ///////////////////////////////////////////////////////////////////////

  // Controller strobes
  logic cap_en;
  logic core_start;
  logic cnt_load;
  logic cnt_step;
  logic out_en;
  logic done;

  // Status back to the controller
  logic both_full;
  logic last;
  logic core_ready;

  // Datapath
  elem_req_t   req;
  float_word_u core_result;

  vfa_ctrl_fsm i_ctrl (
    .CLK        (CLK),
    .RST        (RST),
    .start      (START),
    .both_full  (both_full),
    .core_ready (core_ready),
    .last       (last),
    .cap_en     (cap_en),
    .core_start (core_start),
    .cnt_load   (cnt_load),
    .cnt_step   (cnt_step),
    .out_en     (out_en),
    .done       (done)
  );

  vfa_elem_counter i_counter (
    .CLK  (CLK),
    .RST  (RST),
    .load (cnt_load),
    .step (cnt_step),
    .size (SIZE_IN),
    .last (last)
  );

  // Flags cleared by the launch pulse
  vfa_operand_capture i_capture (
    .CLK       (CLK),
    .RST       (RST),
    .cap_en    (cap_en),
    .clr       (core_start),
    .a_en      (DATA_A_IN_ENABLE),
    .a         (DATA_A_IN),
    .b_en      (DATA_B_IN_ENABLE),
    .b         (DATA_B_IN),
    .op        (OPERATION),
    .both_full (both_full),
    .req       (req)
  );

  vfa_float_add_core i_core (
    .CLK    (CLK),
    .RST    (RST),
    .start  (core_start),
    .req    (req),
    .ready  (core_ready),
    .result (core_result)
  );

  ///////////////////////////////////////////////////////////////////////
  // Output registers
  ///////////////////////////////////////////////////////////////////////

  // One cycle after the core result, READY with the final element
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= out_en;
      READY           <= done;
      if (out_en) DATA_OUT <= core_result.raw;
    end
  end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
  output logic CLK
);

  // Period of 8, low at time zero
  initial begin
    CLK = 1'b0;
  end

  always #4 CLK = ~CLK;

endmodule

/* dv/tb_vector_float_adder.sv */
module tb_vector_float_adder;
  import vfa_pkg::*;

  // One vector element with its hand derived result
  typedef struct packed {
    logic [3:0]         run;
    logic [3:0]         idx;
    logic [FLOAT_W-1:0] a;
    logic [FLOAT_W-1:0] b;
    logic               op;  // 1 = a - b
    logic [FLOAT_W-1:0] res;
  } vec_row_t;

  localparam int N_ROWS  = 8;
  localparam int LAT     = 1 + CORE_LAT + 1;
  localparam int TIMEOUT = 40;

  logic               CLK, RST, START, OPERATION;
  logic               DATA_A_IN_ENABLE, DATA_B_IN_ENABLE;
  logic               READY, DATA_OUT_ENABLE;
  logic [LEN_W-1:0]   SIZE_IN;
  logic [FLOAT_W-1:0] DATA_A_IN, DATA_B_IN, DATA_OUT;

  vec_row_t    rows [N_ROWS];
  int          run_lens [3];
  logic [31:0] lfsr;
  int          checks, errors, timeouts;
  int          n_out, n_ready;

  tb_clk_gen i_clk_gen (.CLK(CLK));

  vector_float_adder i_vector_float_adder (.*);

  // Drive slot one unit past the edge, output pulses counted here
  task automatic tick();
    @(posedge CLK);
    #1;
    if (DATA_OUT_ENABLE) n_out++;
    if (READY) n_ready++;
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  task automatic take_bits(input int n, output int val);
    logic fb;
    val = 0;
    repeat (n) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = (val << 1) | fb;
    end
  endtask

  task automatic check(input logic ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("FAILED %0t: %s", $time, msg);
    end
  endtask

  task automatic finish_run();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // One element, operand strobes in LFSR order, then its result
  task automatic apply_row(input int r);
    int order;
    int gap;
    int lat;
    take_bits(2, order);
    take_bits(2, gap);
    DATA_A_IN = rows[r].a;
    DATA_B_IN = rows[r].b;
    // Wrong operation on a lone first strobe, the second one decides
    OPERATION = (order < 2) ? !rows[r].op : rows[r].op;
    // 0 A first, 1 B first, else both in one cycle
    DATA_A_IN_ENABLE = (order != 1);
    DATA_B_IN_ENABLE = (order != 0);
    if (order < 2) begin
      tick();
      DATA_A_IN_ENABLE = 1'b0;
      DATA_B_IN_ENABLE = 1'b0;
      repeat (gap % 3) tick();
      DATA_A_IN_ENABLE = (order == 1);
      DATA_B_IN_ENABLE = (order == 0);
      OPERATION        = rows[r].op;
    end
    tick();
    // Pair taken, other data on the bus while the core runs
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    DATA_A_IN        = 32'h4120_0000;
    DATA_B_IN        = 32'h4120_0000;
    OPERATION        = !rows[r].op;
    lat = 0;
    while (!DATA_OUT_ENABLE && lat < TIMEOUT) begin
      tick();
      lat++;
      // Stray strobes during COMPUTE
      DATA_A_IN_ENABLE = (lat == 2);
      DATA_B_IN_ENABLE = (lat == 2);
    end
    if (lat >= TIMEOUT) begin
      timeouts++;
      $display("Timeout: no DATA_OUT_ENABLE for run %0d element %0d",
               rows[r].run, rows[r].idx);
    end else begin
      check(lat == LAT, $sformatf("result after %0d cycles, expected %0d", lat, LAT));
      check(DATA_OUT == rows[r].res, $sformatf("run %0d element %0d: DATA_OUT %h, expected %h",
                                               rows[r].run, rows[r].idx, DATA_OUT, rows[r].res));
      check(READY == (rows[r].idx == run_lens[rows[r].run] - 1), "READY on the wrong element");
    end
  endtask

  initial begin
    lfsr = 32'h85e6_931f;
    RST  = 1'b1;
    {START, OPERATION, DATA_A_IN_ENABLE, DATA_B_IN_ENABLE} = '0;
    {SIZE_IN, DATA_A_IN, DATA_B_IN} = '0;
    run_lens = '{1, 3, 4};
    // run, element, a, b, op, expected
    rows[0] = {4'd0, 4'd0, 32'h3FC0_0000, 32'h3E80_0000, 1'b0, 32'h3FE0_0000};
    // Equal operands, sign change, zero operand
    rows[1] = {4'd1, 4'd0, 32'h4040_0000, 32'h4040_0000, 1'b1, 32'h0000_0000};
    rows[2] = {4'd1, 4'd1, 32'h3F80_0000, 32'h4020_0000, 1'b1, 32'hBFC0_0000};
    rows[3] = {4'd1, 4'd2, 32'h0000_0000, 32'h40C0_0000, 1'b0, 32'h40C0_0000};
    // Overflow, mixed signs, flushed subnormal
    rows[4] = {4'd2, 4'd0, 32'h7F00_0000, 32'h7F00_0000, 1'b0, 32'h7F80_0000};
    rows[5] = {4'd2, 4'd1, 32'hBF00_0000, 32'h4080_0000, 1'b0, 32'h4060_0000};
    rows[6] = {4'd2, 4'd2, 32'h4000_0000, 32'h0040_0000, 1'b1, 32'h4000_0000};
    rows[7] = {4'd2, 4'd3, 32'h3F00_0000, 32'hBF80_0000, 1'b1, 32'h3FC0_0000};
    repeat (3) tick();
    RST = 1'b0;
    check(!READY && !DATA_OUT_ENABLE && DATA_OUT == '0, "outputs not clear after reset");
    for (int r = 0; r < N_ROWS && timeouts == 0; r++) begin
      if (rows[r].idx == 0) begin
        // New run, counters restart
        START   = 1'b1;
        SIZE_IN = LEN_W'(run_lens[rows[r].run]);
        tick();
        START   = 1'b0;
        n_out   = 0;
        n_ready = 0;
      end
      apply_row(r);
      if (rows[r].idx == run_lens[rows[r].run] - 1) begin
        check(n_out == run_lens[rows[r].run] && n_ready == 1,
              $sformatf("run %0d: %0d results, %0d READY pulses", rows[r].run, n_out, n_ready));
      end
    end
    finish_run();
  end

endmodule

/* verilog.f */
src/vfa_pkg.sv
src/vfa_ctrl_fsm.sv
src/vfa_elem_counter.sv
src/vfa_operand_capture.sv
src/vfa_float_add_core.sv
src/vector_float_adder.sv
dv/tb_clk_gen.sv
dv/tb_vector_float_adder.sv

/* Bender.yml */
package:
  name: vector_float_adder

sources:
  - files:
      - src/vfa_pkg.sv
      - src/vfa_ctrl_fsm.sv
      - src/vfa_elem_counter.sv
      - src/vfa_operand_capture.sv
      - src/vfa_float_add_core.sv
      - src/vector_float_adder.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_vector_float_adder.sv
